// ==== Makefile ====
# Verilator build and run for the execute unit

.PHONY: all sim lint clean

all: sim

obj_dir/ins_exec_sim: jag_risc_exec.f logic/*.sv testbench/*.sv
	verilator --binary --timing --assert -f jag_risc_exec.f \
		--top-module ins_exec_tb -o ins_exec_sim

sim: obj_dir/ins_exec_sim
	@out=$$(./obj_dir/ins_exec_sim); echo "$$out"; \
		echo "$$out" | grep -qF "Done: no errors"

lint:
	verilator --lint-only -Wall --timing -f jag_risc_exec.f --top-module ins_exec_tb

clean:
	rm -rf obj_dir

// ==== jag_risc_exec.f ====
logic/risc_pkg.sv
logic/ins_decode.sv
logic/srcdgen.sv
logic/reg_file.sv
logic/risc_alu.sv
logic/ins_exec.sv
testbench/ins_exec_tb.sv

// ==== logic/ins_decode.sv ====
// Instruction register, program counter and opcode decode
`timescale 1ns/10ps

module ins_decode import risc_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic [INSTR_W-1:0]  instr,
	input  logic                instr_valid,
	output logic [REG_AW-1:0]   src_reg,
	output logic [REG_AW-1:0]   dst_reg,
	output logic [SRCDAT_W-1:0] srcdat,
	output logic [ALUFN_W-1:0]  alu_fn,
	output logic [DATA_W-1:0]   inst_pc,
	output logic [DATA_W-1:0]   pc,
	output logic                exec_valid,
	output logic                illegal
);

	// Registered instruction word
	logic [INSTR_W-1:0] ir;
	logic [OPC_W-1:0]   opcode;
	// Legality of the incoming opcode, checked before it is registered
	logic               legal_in;

	assign legal_in = (instr[INSTR_W-1 -: OPC_W] <= OP_BCLR);

	// Field split: opcode on top, then source, then destination
	assign opcode  = ir[INSTR_W-1 -: OPC_W];
	assign src_reg = ir[2*REG_AW-1:REG_AW];
	assign dst_reg = ir[REG_AW-1:0];

	// Instruction word and its own program count
	// Count captured before this instruction's increment
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			ir      <= instr;
			inst_pc <= pc;
		end
	end

	// Running program count and stage valids
	always_ff @(posedge clk) begin
		if (rst) begin
			pc         <= '0;
			exec_valid <= 1'b0;
			illegal    <= 1'b0;
		end else begin
			// Every strobe advances the count, illegal ones too
			if (instr_valid)
				pc <= pc + 32'd2;
			exec_valid <= instr_valid & legal_in;
			illegal    <= instr_valid & ~legal_in;
		end
	end

	// Opcode decode
	always_comb begin
		srcdat = SRC_REG;
		alu_fn = ALU_PASS;
		case (opcode)
			OP_ADD:    alu_fn = ALU_ADD;
			OP_SUB:    alu_fn = ALU_SUB;
			OP_AND:    alu_fn = ALU_AND;
			OP_OR:     alu_fn = ALU_OR;
			OP_XOR:    alu_fn = ALU_XOR;
			// Register move, operand passed straight through
			OP_MOVE:   alu_fn = ALU_PASS;
			OP_MOVEQ:  srcdat = SRC_IMM;
			OP_ADDQW: begin
				srcdat = SRC_IMMX4;
				alu_fn = ALU_ADD;
			end
			OP_ADDQN: begin
				srcdat = SRC_NEG;
				alu_fn = ALU_ADD;
			end
			OP_CLR:    srcdat = SRC_ZERO;
			OP_ADDQS: begin
				srcdat = SRC_SIGNED;
				alu_fn = ALU_ADD;
			end
			OP_SETM1:  srcdat = SRC_ONES;
			OP_MOVEPC: srcdat = SRC_PC;
			OP_ADDQ: begin
				srcdat = SRC_IMM32;
				alu_fn = ALU_ADD;
			end
			OP_SUBQ: begin
				srcdat = SRC_IMM32;
				alu_fn = ALU_SUB;
			end
			// Bit set is OR with a one-hot mask
			OP_BSET: begin
				srcdat = SRC_BSET;
				alu_fn = ALU_OR;
			end
			// Bit clear is AND with the inverted mask
			OP_BCLR: begin
				srcdat = SRC_BCLR;
				alu_fn = ALU_AND;
			end
			default: begin
				srcdat = SRC_REG;
				alu_fn = ALU_PASS;
			end
		endcase
	end

	// Execute slot holds a legal opcode and the illegal pulse an illegal one
	// So the two are never high together
	a_exec_legal: assert property (@(posedge clk) disable iff (rst)
		exec_valid |-> (opcode <= OP_BCLR));
	a_illegal_op: assert property (@(posedge clk) disable iff (rst)
		illegal |-> (opcode > OP_BCLR));

endmodule

// ==== logic/ins_exec.sv ====
// Execute unit top level with decode, register file, source generator and ALU
`timescale 1ns/10ps

module ins_exec import risc_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic [INSTR_W-1:0] instr,
	input  logic               instr_valid,
	output logic [DATA_W-1:0]  result,
	output logic [REG_AW-1:0]  result_reg,
	output logic               result_valid,
	output logic [DATA_W-1:0]  pc,
	output logic               flag_z,
	output logic               flag_c,
	output logic               flag_n,
	output logic               illegal
);

	// Decode outputs
	logic [REG_AW-1:0]   src_reg;
	logic [REG_AW-1:0]   dst_reg;
	logic [SRCDAT_W-1:0] srcdat;
	logic [ALUFN_W-1:0]  alu_fn;
	logic [DATA_W-1:0]   inst_pc;
	logic                exec_valid;
	// Register read data
	logic [DATA_W-1:0]   src_data;
	logic [DATA_W-1:0]   dst_data;
	// Local source
	logic                locdent;
	logic [DATA_W-1:0]   locsrc;

	ins_decode u_decode (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.src_reg     (src_reg),
		.dst_reg     (dst_reg),
		.srcdat      (srcdat),
		.alu_fn      (alu_fn),
		.inst_pc     (inst_pc),
		.pc          (pc),
		.exec_valid  (exec_valid),
		.illegal     (illegal)
	);

	// Port a reads the source, port b the destination
	// Write port fed back from the ALU result register
	reg_file u_regs (
		.clk     (clk),
		.rst     (rst),
		.raddr_a (src_reg),
		.raddr_b (dst_reg),
		.we      (result_valid),
		.waddr   (result_reg),
		.wdata   (result),
		.rdata_a (src_data),
		.rdata_b (dst_data)
	);

	// Operand field shares the bits of the source register number
	srcdgen u_srcdgen (
		.locdent       (locdent),
		.locsrc        (locsrc),
		.program_count (inst_pc),
		.srcdat        (srcdat),
		.srcop         (src_reg)
	);

	risc_alu u_alu (
		.clk          (clk),
		.rst          (rst),
		.exec_valid   (exec_valid),
		.alu_fn       (alu_fn),
		.dst_reg      (dst_reg),
		.dst_data     (dst_data),
		.src_data     (src_data),
		.locdent      (locdent),
		.locsrc       (locsrc),
		.result       (result),
		.result_reg   (result_reg),
		.result_valid (result_valid),
		.flag_z       (flag_z),
		.flag_c       (flag_c),
		.flag_n       (flag_n)
	);

endmodule

// ==== logic/reg_file.sv ====
// Register file, 32 by 32, two read ports with write-through and one write port
`timescale 1ns/10ps

module reg_file import risc_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic [REG_AW-1:0] raddr_a,
	input  logic [REG_AW-1:0] raddr_b,
	input  logic              we,
	input  logic [REG_AW-1:0] waddr,
	input  logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata_a,
	output logic [DATA_W-1:0] rdata_b
);

	logic [DATA_W-1:0] regs [0:NUM_REGS-1];
	// Same-cycle write hits on either read port
	logic              hit_a;
	logic              hit_b;

	// All registers come up zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	assign hit_a = we && (waddr == raddr_a);
	assign hit_b = we && (waddr == raddr_b);

	// Write-through so a dependent instruction sees the pending result
	assign rdata_a = hit_a ? wdata : regs[raddr_a];
	assign rdata_b = hit_b ? wdata : regs[raddr_b];

	// Written data comes from a valid execute, never from unknowns
	a_wdata_known: assert property (@(posedge clk) disable iff (rst)
		we |-> !$isunknown(wdata));

endmodule

// ==== logic/risc_alu.sv ====
// Operand select, add/subtract/logic unit, result register and flags
`timescale 1ns/10ps

module risc_alu import risc_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               exec_valid,
	input  logic [ALUFN_W-1:0] alu_fn,
	input  logic [REG_AW-1:0]  dst_reg,
	input  logic [DATA_W-1:0]  dst_data,
	input  logic [DATA_W-1:0]  src_data,
	input  logic               locdent,
	input  logic [DATA_W-1:0]  locsrc,
	output logic [DATA_W-1:0]  result,
	output logic [REG_AW-1:0]  result_reg,
	output logic               result_valid,
	output logic               flag_z,
	output logic               flag_c,
	output logic               flag_n
);

	logic [DATA_W-1:0] operand;
	// One extra bit catches carry out and borrow
	logic [DATA_W:0]   sum_ext;
	logic [DATA_W:0]   diff_ext;
	logic [DATA_W-1:0] alu_out;
	logic              carry_out;

	// Local source wins when the generator claims the operand
	assign operand = locdent ? locsrc : src_data;

	assign sum_ext  = {1'b0, dst_data} + {1'b0, operand};
	// Top bit set means a borrow
	assign diff_ext = {1'b0, dst_data} - {1'b0, operand};

	always_comb begin
		carry_out = 1'b0;
		case (alu_fn)
			ALU_ADD: begin
				alu_out   = sum_ext[DATA_W-1:0];
				carry_out = sum_ext[DATA_W];
			end
			ALU_SUB: begin
				alu_out   = diff_ext[DATA_W-1:0];
				carry_out = diff_ext[DATA_W];
			end
			ALU_AND:  alu_out = dst_data & operand;
			ALU_OR:   alu_out = dst_data | operand;
			ALU_XOR:  alu_out = dst_data ^ operand;
			// Moves and loads of constants
			ALU_PASS: alu_out = operand;
			default:  alu_out = operand;
		endcase
	end

	// Result word and target register
	always_ff @(posedge clk) begin
		if (exec_valid) begin
			result     <= alu_out;
			result_reg <= dst_reg;
		end
	end

	// Write strobe and flags
	// Flags hold across idle cycles, carry is zero for non-arithmetic ops
	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
			flag_z       <= 1'b0;
			flag_c       <= 1'b0;
			flag_n       <= 1'b0;
		end else begin
			result_valid <= exec_valid;
			if (exec_valid) begin
				flag_z <= (alu_out == '0);
				flag_c <= carry_out;
				flag_n <= alu_out[DATA_W-1];
			end
		end
	end

endmodule

// ==== logic/risc_pkg.sv ====
// Widths, opcodes, source-data types and ALU function codes for the execute unit
package risc_pkg;

	// Instruction format and datapath widths
	localparam int INSTR_W  = 16;
	localparam int DATA_W   = 32;
	localparam int REG_AW   = 5;
	localparam int NUM_REGS = 32;
	localparam int OPC_W    = 6;
	localparam int SRCDAT_W = 4;
	localparam int ALUFN_W  = 3;

	// Opcodes
	// Register forms first, then the local source forms
	localparam logic [OPC_W-1:0] OP_ADD    = 6'd0;
	localparam logic [OPC_W-1:0] OP_SUB    = 6'd1;
	localparam logic [OPC_W-1:0] OP_AND    = 6'd2;
	localparam logic [OPC_W-1:0] OP_OR     = 6'd3;
	localparam logic [OPC_W-1:0] OP_XOR    = 6'd4;
	localparam logic [OPC_W-1:0] OP_MOVE   = 6'd5;
	localparam logic [OPC_W-1:0] OP_MOVEQ  = 6'd6;
	localparam logic [OPC_W-1:0] OP_ADDQW  = 6'd7;
	localparam logic [OPC_W-1:0] OP_ADDQN  = 6'd8;
	localparam logic [OPC_W-1:0] OP_CLR    = 6'd9;
	localparam logic [OPC_W-1:0] OP_ADDQS  = 6'd10;
	localparam logic [OPC_W-1:0] OP_SETM1  = 6'd11;
	localparam logic [OPC_W-1:0] OP_MOVEPC = 6'd12;
	localparam logic [OPC_W-1:0] OP_ADDQ   = 6'd13;
	localparam logic [OPC_W-1:0] OP_SUBQ   = 6'd14;
	localparam logic [OPC_W-1:0] OP_BSET   = 6'd15;
	// Highest legal opcode, anything above is illegal
	localparam logic [OPC_W-1:0] OP_BCLR   = 6'd16;

	// Source-data types for the local source generator
	localparam logic [SRCDAT_W-1:0] SRC_REG    = 4'd0;
	localparam logic [SRCDAT_W-1:0] SRC_IMM    = 4'd1;
	localparam logic [SRCDAT_W-1:0] SRC_IMMX4  = 4'd2;
	localparam logic [SRCDAT_W-1:0] SRC_NEG    = 4'd3;
	localparam logic [SRCDAT_W-1:0] SRC_ZERO   = 4'd4;
	localparam logic [SRCDAT_W-1:0] SRC_SIGNED = 4'd5;
	localparam logic [SRCDAT_W-1:0] SRC_ONES   = 4'd6;
	localparam logic [SRCDAT_W-1:0] SRC_PC     = 4'd7;
	localparam logic [SRCDAT_W-1:0] SRC_IMM32  = 4'd8;
	localparam logic [SRCDAT_W-1:0] SRC_BSET   = 4'd9;
	localparam logic [SRCDAT_W-1:0] SRC_BCLR   = 4'd10;

	// ALU functions
	localparam logic [ALUFN_W-1:0] ALU_ADD  = 3'd0;
	localparam logic [ALUFN_W-1:0] ALU_SUB  = 3'd1;
	localparam logic [ALUFN_W-1:0] ALU_AND  = 3'd2;
	localparam logic [ALUFN_W-1:0] ALU_OR   = 3'd3;
	localparam logic [ALUFN_W-1:0] ALU_XOR  = 3'd4;
	localparam logic [ALUFN_W-1:0] ALU_PASS = 3'd5;

endpackage

// ==== logic/srcdgen.sv ====
// Local source generator for constants, immediates, bit masks and the program count
`timescale 1ns/10ps

module srcdgen import risc_pkg::*; (
	output logic                locdent,
	output logic [DATA_W-1:0]   locsrc,
	input  logic [DATA_W-1:0]   program_count,
	input  logic [SRCDAT_W-1:0] srcdat,
	input  logic [REG_AW-1:0]   srcop
);

	// Operand field of zero, stands for 32 in the one-to-32 form
	logic               opzero;
	// Low bits shared by the small immediate forms
	logic [REG_AW-1:0]  botsrc;
	// Upper fill for the sign-carrying forms
	logic               topsrc;
	logic [DATA_W-1:0]  gensrc;
	// One-hot bit mask and its complement
	logic [DATA_W-1:0]  onebit;
	logic [DATA_W-1:0]  mask;
	// Final select
	logic               type_pc;
	logic               type_mask;

	// Type 0 takes register data, anything else is local
	assign locdent = |srcdat;

	assign opzero = ~|srcop;

	// Bottom five bits
	// Word step keeps only the low three operand bits
	always_comb begin
		case (srcdat)
			SRC_IMMX4: botsrc = {srcop[2:0], 2'b00};
			SRC_ZERO:  botsrc = '0;
			SRC_ONES:  botsrc = '1;
			default:   botsrc = srcop;
		endcase
	end

	// Upper bits are ones for negative and all-ones, sign for signed
	always_comb begin
		case (srcdat)
			SRC_NEG:    topsrc = 1'b1;
			SRC_ONES:   topsrc = 1'b1;
			SRC_SIGNED: topsrc = srcop[REG_AW-1];
			default:    topsrc = 1'b0;
		endcase
	end

	// Bit 5 doubles as the 32 of the one-to-32 form
	always_comb begin
		gensrc = {{(DATA_W-REG_AW){topsrc}}, botsrc};
		if (srcdat == SRC_IMM32)
			gensrc[REG_AW] = opzero;
	end

	// Operand bit 4 picks the low half, so the index is op XOR 16
	assign onebit = 32'h1 << (srcop ^ 5'h10);
	assign mask   = (srcdat == SRC_BCLR) ? ~onebit : onebit;

	assign type_pc   = (srcdat == SRC_PC);
	assign type_mask = (srcdat == SRC_BSET) || (srcdat == SRC_BCLR);

	assign locsrc = type_pc ? program_count :
		(type_mask ? mask : gensrc);

	// Decode never hands over a type above 10
	always_comb begin
		a_srcdat_range: assert final (srcdat <= SRC_BCLR);
	end

endmodule

// ==== testbench/ins_exec_tb.sv ====
// Testbench for the execute unit with random stimulus, reference model and assertions
`timescale 1ns/10ps

module ins_exec_tb import risc_pkg::*; ();

	localparam logic [31:0] SEED = 32'hf600_65b9;
	localparam int N_RESET = 4;
	localparam int N_IMM   = 256;
	localparam int N_MASK  = 64;
	localparam int N_PC    = 16;
	localparam int N_REG   = 200;
	localparam int N_ILL   = 24;
	// Each test drains for four cycles, PC test has up to two idle cycles per strobe
	localparam int TEST_CYCLES = 4 + N_RESET + N_IMM + N_MASK + 3 * N_PC + N_REG
		+ N_ILL + 32 + 6 * 4;
	localparam int MAX_CYCLES  = 2 * TEST_CYCLES + 100;

	logic        clk;
	logic        rst;
	logic [15:0] instr;
	logic        instr_valid;
	logic [31:0] result;
	logic [4:0]  result_reg;
	logic        result_valid;
	logic [31:0] pc;
	logic        flag_z;
	logic        flag_c;
	logic        flag_n;
	logic        illegal;

	// Reference state
	logic [31:0] mregs [0:31];
	logic [31:0] pc_model;
	logic [15:0] exec_instr;
	logic [31:0] exec_pc;
	logic        exec_pend;
	logic [32:0] exec_out;
	logic [31:0] exp_result;
	logic [4:0]  exp_reg;
	logic        exp_z;
	logic        exp_c;
	logic        exp_n;

	int err_count = 0;
	int test_count = 0;
	int test_fails = 0;
	int err_mark = 0;
	int cycles = 0;

	ins_exec DUT (
		.clk          (clk),
		.rst          (rst),
		.instr        (instr),
		.instr_valid  (instr_valid),
		.result       (result),
		.result_reg   (result_reg),
		.result_valid (result_valid),
		.pc           (pc),
		.flag_z       (flag_z),
		.flag_c       (flag_c),
		.flag_n       (flag_n),
		.illegal      (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Carry in bit 32, result below, from the instruction set rules
	function automatic logic [32:0] expect_exec(input logic [15:0] ins,
		input logic [31:0] ipc, input logic [31:0] d, input logic [31:0] s);
		logic [4:0]  op;
		logic [31:0] bitm;
		logic [31:0] q32;
		op   = ins[9:5];
		bitm = 32'h1 << (op ^ 5'd16);
		// Quick add and subtract cover 1 to 32
		q32  = (op == 5'd0) ? 32'd32 : 32'(op);
		case (ins[15:10])
			OP_ADD:    return {1'b0, d} + {1'b0, s};
			OP_SUB:    return {1'b0, d} - {1'b0, s};
			OP_AND:    return {1'b0, d & s};
			OP_OR:     return {1'b0, d | s};
			OP_XOR:    return {1'b0, d ^ s};
			OP_MOVE:   return {1'b0, s};
			OP_MOVEQ:  return {1'b0, 32'(op)};
			OP_ADDQW:  return {1'b0, d} + {1'b0, 32'(op % 5'd8) * 32'd4};
			OP_ADDQN:  return {1'b0, d} + {1'b0, 32'(op) - 32'd32};
			OP_CLR:    return 33'd0;
			OP_ADDQS:  return {1'b0, d} + {1'b0, {{27{op[4]}}, op}};
			OP_SETM1:  return {1'b0, 32'hffff_ffff};
			OP_MOVEPC: return {1'b0, ipc};
			OP_ADDQ:   return {1'b0, d} + {1'b0, q32};
			OP_SUBQ:   return {1'b0, d} - {1'b0, q32};
			OP_BSET:   return {1'b0, d | bitm};
			OP_BCLR:   return {1'b0, d & ~bitm};
			default:   return 33'd0;
		endcase
	endfunction

	// Model runs each legal instruction one edge after its strobe, in order
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				mregs[i] = '0;
			pc_model  = '0;
			exec_pend = 1'b0;
			exp_z <= 1'b0;
			exp_c <= 1'b0;
			exp_n <= 1'b0;
		end else begin
			if (exec_pend) begin
				exec_out = expect_exec(exec_instr, exec_pc, mregs[exec_instr[4:0]],
					mregs[exec_instr[9:5]]);
				mregs[exec_instr[4:0]] = exec_out[31:0];
				exp_result <= exec_out[31:0];
				exp_reg    <= exec_instr[4:0];
				exp_z      <= (exec_out[31:0] == 32'd0);
				exp_c      <= exec_out[32];
				exp_n      <= exec_out[31];
			end
			exec_pend  = instr_valid && (instr[15:10] <= OP_BCLR);
			exec_instr = instr;
			exec_pc    = pc_model;
			if (instr_valid)
				pc_model = pc_model + 32'd2;
		end
	end

	// Result two edges after a legal strobe, illegal pulse one edge after
	a_latency: assert property (@(posedge clk) disable iff (rst)
		result_valid == $past(instr_valid && (instr[15:10] <= OP_BCLR), 2))
		else begin
			err_count++;
			$display("ERR result_valid: got %h expected %h", $sampled(result_valid),
				!$sampled(result_valid));
		end
	a_illegal: assert property (@(posedge clk) disable iff (rst)
		illegal == $past(instr_valid && (instr[15:10] > OP_BCLR)))
		else begin
			err_count++;
			$display("ERR illegal: got %h expected %h", $sampled(illegal), !$sampled(illegal));
		end
	a_reset_state: assert property (@(posedge clk)
		$fell(rst) |-> (!result_valid && !illegal && pc == 32'd0))
		else begin
			err_count++;
			$display("Outputs not cleared after reset");
		end
	a_result: assert property (@(posedge clk) disable iff (rst)
		result_valid |-> result == exp_result)
		else begin
			err_count++;
			$display("ERR result: got %h expected %h", $sampled(result), $sampled(exp_result));
		end
	a_result_reg: assert property (@(posedge clk) disable iff (rst)
		result_valid |-> result_reg == exp_reg)
		else begin
			err_count++;
			$display("ERR result_reg: got %h expected %h", $sampled(result_reg),
				$sampled(exp_reg));
		end
	a_pc: assert property (@(posedge clk) disable iff (rst) pc == pc_model)
		else begin
			err_count++;
			$display("ERR pc: got %h expected %h", $sampled(pc), $sampled(pc_model));
		end
	// Flags must also hold across idle cycles
	a_flags: assert property (@(posedge clk) disable iff (rst)
		{flag_z, flag_c, flag_n} == {exp_z, exp_c, exp_n})
		else begin
			err_count++;
			$display("ERR flag_z/c/n: got %h expected %h",
				$sampled({flag_z, flag_c, flag_n}), $sampled({exp_z, exp_c, exp_n}));
		end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Run stopped after %0d cycles without finishing", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic logic [4:0] rand_field();
		return 5'($urandom % 32);
	endfunction

	// One strobe per call, so successive calls are back to back
	task automatic send(input logic [5:0] opc, input logic [4:0] op, input logic [4:0] rd);
		@(posedge clk);
		instr       <= {opc, op, rd};
		instr_valid <= 1'b1;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			instr_valid <= 1'b0;
		end
	endtask

	task automatic end_test(input string name);
		idle(4);
		test_count++;
		if (err_count != err_mark)
			test_fails++;
		$display("Test %0d %s: %0d errors", test_count, name, err_count - err_mark);
		err_mark = err_count;
	endtask

	initial begin
		logic [5:0] imm_ops [0:7];
		imm_ops = '{OP_MOVEQ, OP_CLR, OP_SETM1, OP_ADDQW, OP_ADDQN, OP_ADDQS, OP_ADDQ, OP_SUBQ};
		rst         = 1'b1;
		instr       = '0;
		instr_valid = 1'b0;
		void'($urandom(SEED));
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// All registers read zero at first
		for (int i = 0; i < N_RESET; i++)
			send(OP_MOVE, rand_field(), rand_field());
		end_test("reset");

		// Every operand value through every immediate form
		for (int i = 0; i < N_IMM; i++)
			send(imm_ops[i / 32], 5'(i % 32), rand_field());
		end_test("immediates");

		for (int i = 0; i < N_MASK; i++)
			send(($urandom % 2) ? OP_BSET : OP_BCLR, rand_field(), rand_field());
		end_test("bit masks");

		for (int i = 0; i < N_PC; i++) begin
			send(OP_MOVEPC, rand_field(), rand_field());
			idle($urandom % 3);
		end
		end_test("program count");

		// Few registers so most instructions depend on the one before
		for (int i = 0; i < N_REG; i++)
			send(6'($urandom % 6), 5'($urandom % 4), 5'($urandom % 4));
		end_test("register forms");

		for (int i = 0; i < N_ILL; i++)
			send(6'(17 + $urandom % 47), rand_field(), rand_field());
		// Read every register back to show nothing changed
		for (int i = 0; i < 32; i++)
			send(OP_MOVE, 5'(i), 5'(i));
		end_test("illegal opcodes");

		$display("Tests: %0d run, %0d failed, %0d errors", test_count, test_fails, err_count);
		if (err_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
